// ==== flist.f ====
src/pic_isa_pkg.sv
src/ctrl_pkg.sv
src/decoded_insn_if.sv
src/insn_decoder.sv
src/cycle_sequencer.sv
src/strobe_encoder.sv
src/control_unit.sv
tests/control_unit_assert.sv
tests/tb_control_unit.sv

// ==== run.sh ====
#!/bin/sh
# Builds the testbench with Verilator and runs it; exit status carries the result
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_control_unit -f flist.f &&
./obj_dir/Vtb_control_unit +verilator+error+limit+100 || exit 1

// ==== tests/tb_control_unit.sv ====
`timescale 1ns/1ps

module tb_control_unit
        import pic_isa_pkg::*;
        import ctrl_pkg::*;
();

        localparam int num_insns   = 300;
        localparam int cycle_limit = 1400;

        logic              clk;
        logic              rst_n;
        logic [insn_w-1:0] instruction;
        logic              z_flag;
        logic              skip_test;
        logic              load_ins;
        logic              sel_code;
        logic              inc_pc;
        logic              en_addr;
        logic              load_w;
        logic              write;
        logic              load_c;
        logic              load_z;
        logic              load_dc;
        logic              load_from_pc;
        logic              load_from_stk1;
        logic              load_from_stk2;
        logic              load_pc_from_literal;
        logic              load_stk1_to_pc;
        logic              pch8_mux_sel;

        logic              fetch_seen;
        int                cycles;
        int                issued;

        control_unit u_control_unit (.*);

        initial begin
                clk = 1'b0;
                forever #5 clk = ~clk;
        end

        // Base encoding and free field bits of each instruction kind
        function automatic logic [11:0] pick_insn(input int kind, input logic [11:0] r);
                logic [11:0] base;
                logic [11:0] mask;
                mask = 12'h03f;
                case (kind)
                        0: begin base = 12'h000; mask = 12'h000; end
                        1: begin base = 12'h002; mask = 12'h000; end
                        2: begin base = 12'h003; mask = 12'h000; end
                        3: begin base = 12'h004; mask = 12'h000; end
                        4: begin base = 12'h005; mask = 12'h000; end
                        5: begin base = 12'h006; mask = 12'h001; end
                        6: begin base = 12'h020; mask = 12'h01f; end
                        7: begin base = 12'h040; mask = 12'h000; end
                        8: begin base = 12'h060; mask = 12'h01f; end
                        27: begin base = 12'h800; mask = 12'h0ff; end
                        28: begin base = 12'h900; mask = 12'h0ff; end
                        29: begin base = 12'ha00; mask = 12'h1ff; end
                        default: begin
                                if (kind < 23) begin
                                        // Byte ops from SUBWF at 0x080 in steps of 0x40
                                        base = 12'(12'h080 + (kind - 9) * 12'h040);
                                end else if (kind < 27) begin
                                        base = 12'(12'h400 + (kind - 23) * 12'h100);
                                        mask = 12'h0ff;
                                end else begin
                                        base = 12'(12'hc00 + (kind - 30) * 12'h100);
                                        mask = 12'h0ff;
                                end
                        end
                endcase
                return base | (r & mask);
        endfunction

        function automatic string check_name(input int id);
                case (id)
                        1: return "outputs in reset";
                        2: return "load_ins";
                        3: return "load_ins period";
                        4: return "inc_pc";
                        5: return "en_addr";
                        6: return "perform strobes";
                        7: return "sel_code";
                        default: return "perform strobes of dropped op";
                endcase
        endfunction

        always @(negedge clk) begin
                if (u_control_unit.u_checker.fail_count != 0) begin
                        $display("CHECK FAILED at %0t: %s expected %h got %h", $time,
                                 check_name(u_control_unit.u_checker.fail_id),
                                 u_control_unit.u_checker.fail_exp,
                                 u_control_unit.u_checker.fail_act);
                        $display("Simulation finished: FAIL");
                        $fatal(1, "assertion failure");
                end
        end

        always @(posedge clk) begin
                cycles <= cycles + 1;
                if (cycles >= cycle_limit) begin
                        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
                        $display("Simulation finished: FAIL");
                        $fatal(1, "timeout");
                end
        end

        initial begin
                void'($urandom(59627));
                cycles      = 0;
                issued      = 0;
                fetch_seen  = 1'b0;
                rst_n       = 1'b0;
                instruction = '0;
                z_flag      = 1'b0;
                skip_test   = 1'b0;
                repeat (8) @(posedge clk);
                #1 rst_n = 1'b1;
                while (issued < num_insns) begin
                        @(negedge clk);
                        fetch_seen = load_ins;
                        @(posedge clk);
                        #1;
                        z_flag    = 1'($urandom);
                        skip_test = 1'($urandom);
                        // IR takes the new word at the edge closing load_ins
                        if (fetch_seen) begin
                                instruction = pick_insn(int'($urandom % 34), 12'($urandom));
                                issued++;
                        end
                end
                repeat (8) @(posedge clk);
                if (u_control_unit.u_checker.fail_count != 0) begin
                        $display("Simulation finished: FAIL");
                        $fatal(1, "assertion failure");
                end else begin
                        $display("Simulation finished: PASS");
                        $finish;
                end
        end

endmodule

// ==== tests/control_unit_assert.sv ====
`timescale 1ns/1ps

module control_unit_assert
        import pic_isa_pkg::*;
(
        input logic              clk,
        input logic              rst_n,
        input logic [insn_w-1:0] instruction,
        input logic              z_flag,
        input logic              skip_test,
        input logic              load_ins,
        input logic              sel_code,
        input logic              inc_pc,
        input logic              en_addr,
        input logic              load_w,
        input logic              write,
        input logic              load_c,
        input logic              load_z,
        input logic              load_dc,
        input logic              load_from_pc,
        input logic              load_from_stk1,
        input logic              load_from_stk2,
        input logic              load_pc_from_literal,
        input logic              load_stk1_to_pc,
        input logic              pch8_mux_sel
);

        // Read by the testbench top
        int          fail_count = 0;
        int          fail_id = 0;
        logic [15:0] fail_exp;
        logic [15:0] fail_act;

        // Step 0 idle, 1 pc, 2..3 nop, 4 first fetch, then 5..8 repeating
        logic [3:0]  step;
        logic        rst_seen;
        logic [10:0] perf;
        logic [10:0] exp_perf;
        logic [14:0] all_out;
        logic        file_op;
        logic        zero_kind;
        logic        test_kind;
        logic        exp_sel;

        always_ff @(posedge clk) begin
                if (!rst_n) begin
                        step     <= 4'd0;
                        rst_seen <= 1'b1;
                end else if (step == 4'd8) begin
                        step <= 4'd5;
                end else begin
                        step <= step + 4'd1;
                end
        end

        // Order: w, file, C, Z, DC, push pc, push stk1, pop stk2, lit pc, pop pc, pch8
        function automatic logic [10:0] perform_mask(input logic [11:0] i);
                logic        d;
                logic [10:0] m;
                d = i[5];
                m = '0;
                casez (i)
                        12'b0000_001?_????: m[9] = 1'b1;
                        12'b0000_0100_0000: m[10] = 1'b1;
                        12'b0000_011?_????: m = 11'b010_1000_0000;
                        12'b0000_10??_????, 12'b0001_11??_????: begin
                                m = 11'b001_1100_0000;
                                m[9]  = d;
                                m[10] = !d;
                        end
                        12'b0000_11??_????, 12'b0001_0???_????, 12'b0001_10??_????,
                        12'b0010_0???_????, 12'b0010_10??_????: begin
                                m[7]  = 1'b1;
                                m[9]  = d;
                                m[10] = !d;
                        end
                        12'b0011_0???_????: begin
                                m[8]  = 1'b1;
                                m[9]  = d;
                                m[10] = !d;
                        end
                        12'b0010_11??_????, 12'b0011_1???_????: begin
                                m[9]  = d;
                                m[10] = !d;
                        end
                        12'b010?_????_????: m[9] = 1'b1;
                        12'b1000_????_????: m = 11'b100_0000_1010;
                        12'b1001_????_????: m = 11'b000_0011_0100;
                        12'b101?_????_????: m = 11'b000_0000_0101;
                        12'b1100_????_????: m[10] = 1'b1;
                        12'b1101_????_????, 12'b111?_????_????: m = 11'b100_1000_0000;
                        default: m = '0;
                endcase
                return m;
        endfunction

        assign perf = {load_w, write, load_c, load_z, load_dc, load_from_pc, load_from_stk1,
                       load_from_stk2, load_pc_from_literal, load_stk1_to_pc, pch8_mux_sel};
        assign all_out = {load_ins, sel_code, inc_pc, en_addr, perf};

        assign file_op = (instruction[11:8] != 4'h0 && !instruction[11]) ||
                         (instruction[11:8] == 4'h0 && instruction[7:5] != 3'b000 &&
                          instruction[7:5] != 3'b010);
        assign zero_kind = instruction[11:9] == 3'b001 && instruction[7:6] == 2'b11;
        assign test_kind = instruction[11:9] == 3'b011;
        assign exp_perf  = (step == 4'd6) ? perform_mask(instruction) : '0;
        assign exp_sel   = step == 4'd8 && ((zero_kind && z_flag) || (test_kind && skip_test));

        task automatic note_fail(input int id, input logic [15:0] exp, input logic [15:0] act);
                fail_id  = id;
                fail_exp = exp;
                fail_act = act;
                fail_count++;
                $error("assertion %0d failed", id);
        endtask

        a_reset_quiet: assert property (@(posedge clk) (rst_seen && !rst_n) |-> all_out == '0)
                else note_fail(1, 16'h0, {1'b0, $sampled(all_out)});

        // Power-up fetch up to and including the first load_ins
        a_load_ins: assert property (@(posedge clk) disable iff (!rst_n)
                (step <= 4'd4) |-> load_ins == (step == 4'd4))
                else note_fail(2, {15'b0, !$sampled(load_ins)}, {15'b0, $sampled(load_ins)});

        a_ins_period: assert property (@(posedge clk) disable iff (!rst_n)
                (step >= 4'd5) |-> load_ins == $past(load_ins, 4))
                else note_fail(3, {15'b0, !$sampled(load_ins)}, {15'b0, $sampled(load_ins)});

        a_inc_pc: assert property (@(posedge clk) disable iff (!rst_n)
                inc_pc == (step == 4'd1 || step == 4'd5))
                else note_fail(4, {15'b0, !$sampled(inc_pc)}, {15'b0, $sampled(inc_pc)});

        a_en_addr: assert property (@(posedge clk) disable iff (!rst_n)
                en_addr == (step == 4'd5 && file_op))
                else note_fail(5, {15'b0, !$sampled(en_addr)}, {15'b0, $sampled(en_addr)});

        a_perform: assert property (@(posedge clk) disable iff (!rst_n) perf == exp_perf)
                else note_fail(6, {5'b0, $sampled(exp_perf)}, {5'b0, $sampled(perf)});

        a_sel_code: assert property (@(posedge clk) disable iff (!rst_n) sel_code == exp_sel)
                else note_fail(7, {15'b0, $sampled(exp_sel)}, {15'b0, $sampled(sel_code)});

        // Dropped instructions sit in the 0000_000x_xxxx corner
        a_dropped_quiet: assert property (@(posedge clk) disable iff (!rst_n)
                (step == 4'd6 && instruction[11:5] == 7'd0) |-> perf == '0)
                else note_fail(8, 16'h0, {5'b0, $sampled(perf)});

endmodule

bind control_unit control_unit_assert u_checker (.*);

// ==== src/control_unit.sv ====
`timescale 1ns/1ps

module control_unit
        import pic_isa_pkg::*;
        import ctrl_pkg::*;
(
        input  logic              clk,
        input  logic              rst_n,
        input  logic [insn_w-1:0] instruction,
        input  logic              z_flag,
        input  logic              skip_test,
        output logic              load_ins,
        output logic              sel_code,
        output logic              inc_pc,
        output logic              en_addr,
        output logic              load_w,
        output logic              write,
        output logic              load_c,
        output logic              load_z,
        output logic              load_dc,
        output logic              load_from_pc,
        output logic              load_from_stk1,
        output logic              load_from_stk2,
        output logic              load_pc_from_literal,
        output logic              load_stk1_to_pc,
        output logic              pch8_mux_sel
);

        phase_e phase;

        decoded_insn_if dec_if ();

        insn_decoder u_insn_decoder (
                .instruction (instruction),
                .dec         (dec_if.decoder)
        );

        cycle_sequencer u_cycle_sequencer (
                .clk       (clk),
                .rst_n     (rst_n),
                .dec       (dec_if.sequencer),
                .z_flag    (z_flag),
                .skip_test (skip_test),
                .phase     (phase),
                .load_ins  (load_ins),
                .sel_code  (sel_code)
        );

        strobe_encoder u_strobe_encoder (
                .phase                (phase),
                .dec                  (dec_if.encoder),
                .inc_pc               (inc_pc),
                .en_addr              (en_addr),
                .load_w               (load_w),
                .write                (write),
                .load_c               (load_c),
                .load_z               (load_z),
                .load_dc              (load_dc),
                .load_from_pc         (load_from_pc),
                .load_from_stk1       (load_from_stk1),
                .load_from_stk2       (load_from_stk2),
                .load_pc_from_literal (load_pc_from_literal),
                .load_stk1_to_pc      (load_stk1_to_pc),
                .pch8_mux_sel         (pch8_mux_sel)
        );

endmodule

// ==== src/strobe_encoder.sv ====
`timescale 1ns/1ps

module strobe_encoder
        import pic_isa_pkg::*;
        import ctrl_pkg::*;
(
        input  phase_e           phase,
        decoded_insn_if.encoder  dec,
        output logic             inc_pc,
        output logic             en_addr,
        output logic             load_w,
        output logic             write,
        output logic             load_c,
        output logic             load_z,
        output logic             load_dc,
        output logic             load_from_pc,
        output logic             load_from_stk1,
        output logic             load_from_stk2,
        output logic             load_pc_from_literal,
        output logic             load_stk1_to_pc,
        output logic             pch8_mux_sel
);

        always_comb begin
                inc_pc               = 1'b0;
                en_addr              = 1'b0;
                load_w               = 1'b0;
                write                = 1'b0;
                load_c               = 1'b0;
                load_z               = 1'b0;
                load_dc              = 1'b0;
                load_from_pc         = 1'b0;
                load_from_stk1       = 1'b0;
                load_from_stk2       = 1'b0;
                load_pc_from_literal = 1'b0;
                load_stk1_to_pc      = 1'b0;
                pch8_mux_sel         = 1'b0;

                case (phase)
                        ph_pc: inc_pc = 1'b1;
                        ph_decode: begin
                                inc_pc  = 1'b1;
                                en_addr = dec.uses_file;
                        end
                        ph_perform: begin
                                case (dec.opcode)
                                        addwf, subwf: begin
                                                write   = dec.dest_f;
                                                load_w  = !dec.dest_f;
                                                load_c  = 1'b1;
                                                load_z  = 1'b1;
                                                load_dc = 1'b1;
                                        end
                                        andwf, comf, decf, incf, iorwf, movf, xorwf: begin
                                                write  = dec.dest_f;
                                                load_w = !dec.dest_f;
                                                load_z = 1'b1;
                                        end
                                        rlf, rrf: begin
                                                write  = dec.dest_f;
                                                load_w = !dec.dest_f;
                                                load_c = 1'b1;
                                        end
                                        decfsz, incfsz, swapf: begin
                                                write  = dec.dest_f;
                                                load_w = !dec.dest_f;
                                        end
                                        clrf: begin
                                                write  = 1'b1;
                                                load_z = 1'b1;
                                        end
                                        clrw, movlw: load_w = 1'b1;
                                        movwf, bcf, bsf: write = 1'b1;
                                        andlw, iorlw, xorlw: begin
                                                load_w = 1'b1;
                                                load_z = 1'b1;
                                        end
                                        call: begin
                                                // Push PC to level 1, level 1 to level 2
                                                load_from_pc         = 1'b1;
                                                load_from_stk1       = 1'b1;
                                                load_pc_from_literal = 1'b1;
                                        end
                                        goto_op: begin
                                                load_pc_from_literal = 1'b1;
                                                pch8_mux_sel         = 1'b1;
                                        end
                                        retlw: begin
                                                load_w          = 1'b1;
                                                load_stk1_to_pc = 1'b1;
                                                load_from_stk2  = 1'b1;
                                        end
                                        // NOP and bit tests only steer the skip
                                        default: ;
                                endcase
                        end
                        default: ;
                endcase
        end

endmodule

// ==== src/cycle_sequencer.sv ====
`timescale 1ns/1ps

module cycle_sequencer
        import ctrl_pkg::*;
(
        input  logic               clk,
        input  logic               rst_n,
        decoded_insn_if.sequencer  dec,
        input  logic               z_flag,
        input  logic               skip_test,
        output phase_e             phase,
        output logic               load_ins,
        output logic               sel_code
);

        phase_e state;
        phase_e next_state;

        always_ff @(posedge clk) begin
                if (!rst_n)
                        state <= ph_idle;
                else
                        state <= next_state;
        end

        always_comb begin
                case (state)
                        ph_idle:     next_state = ph_pc;
                        ph_pc:       next_state = ph_nop1;
                        ph_nop1:     next_state = ph_nop2;
                        ph_nop2:     next_state = ph_get_ins;
                        ph_get_ins:  next_state = ph_decode;
                        ph_decode:   next_state = ph_perform;
                        ph_perform:  next_state = ph_wait;
                        ph_wait:     next_state = ph_get_ins1;
                        ph_get_ins1: next_state = ph_decode;
                        default:     next_state = ph_idle;
                endcase
        end

        assign phase    = state;
        assign load_ins = (state == ph_get_ins) || (state == ph_get_ins1);

        // IR still holds the previous instruction during ph_get_ins1
        always_comb begin
                sel_code = 1'b0;
                if (state == ph_get_ins1) begin
                        case (dec.skip_kind)
                                skip_on_zero: sel_code = z_flag;
                                skip_on_test: sel_code = skip_test;
                                default:      sel_code = 1'b0;
                        endcase
                end
        end

endmodule

// ==== src/insn_decoder.sv ====
`timescale 1ns/1ps

module insn_decoder
        import pic_isa_pkg::*;
        import ctrl_pkg::*;
(
        input  logic [insn_w-1:0] instruction,
        decoded_insn_if.decoder   dec
);

        logic [opc_hi-opc_lo:0] major;
        logic [fn_hi-fn_lo:0]   fn;
        opcode_e                op;

        assign major = instruction[opc_hi:opc_lo];
        assign fn    = instruction[fn_hi:fn_lo];

        always_comb begin
                op = op_nop;
                case (major)
                        4'h0: begin
                                case (fn)
                                        2'b00: begin
                                                // OPTION, TRIS, SLEEP, CLRWDT fall through as NOP
                                                if (instruction[dest_bit])
                                                        op = movwf;
                                        end
                                        2'b01: begin
                                                if (instruction[dest_bit])
                                                        op = clrf;
                                                else if (instruction[dest_bit-1:0] == '0)
                                                        op = clrw;
                                        end
                                        2'b10: op = subwf;
                                        default: op = decf;
                                endcase
                        end
                        4'h1: begin
                                case (fn)
                                        2'b00: op = iorwf;
                                        2'b01: op = andwf;
                                        2'b10: op = xorwf;
                                        default: op = addwf;
                                endcase
                        end
                        4'h2: begin
                                case (fn)
                                        2'b00: op = movf;
                                        2'b01: op = comf;
                                        2'b10: op = incf;
                                        default: op = decfsz;
                                endcase
                        end
                        4'h3: begin
                                case (fn)
                                        2'b00: op = rrf;
                                        2'b01: op = rlf;
                                        2'b10: op = swapf;
                                        default: op = incfsz;
                                endcase
                        end
                        // Bit operations
                        4'h4: op = bcf;
                        4'h5: op = bsf;
                        4'h6: op = btfsc;
                        4'h7: op = btfss;
                        // Control transfer and literals
                        4'h8: op = retlw;
                        4'h9: op = call;
                        4'ha, 4'hb: op = goto_op;
                        4'hc: op = movlw;
                        4'hd: op = iorlw;
                        4'he: op = andlw;
                        default: op = xorlw;
                endcase
        end

        assign dec.opcode = op;
        assign dec.dest_f = instruction[dest_bit];

        assign dec.uses_file = op inside {addwf, andwf, clrf, comf, decf, decfsz, incf,
                                          incfsz, iorwf, movf, movwf, rlf, rrf, subwf,
                                          swapf, xorwf, bcf, bsf, btfsc, btfss};

        always_comb begin
                case (op)
                        decfsz, incfsz: dec.skip_kind = skip_on_zero;
                        btfsc, btfss:   dec.skip_kind = skip_on_test;
                        default:        dec.skip_kind = skip_none;
                endcase
        end

endmodule

// ==== src/decoded_insn_if.sv ====
`timescale 1ns/1ps

interface decoded_insn_if
        import pic_isa_pkg::*;
        import ctrl_pkg::*;
();

        opcode_e    opcode;
        logic       dest_f;
        logic       uses_file;
        skip_kind_e skip_kind;

        modport decoder (
                output opcode,
                output dest_f,
                output uses_file,
                output skip_kind
        );

        modport sequencer (input skip_kind);

        modport encoder (
                input opcode,
                input dest_f,
                input uses_file
        );

endinterface

// ==== src/ctrl_pkg.sv ====
package ctrl_pkg;

        // Four-phase cycle, preceded by the power-up fetch
        typedef enum logic [3:0] {
                ph_idle     = 4'd0,
                ph_pc       = 4'd1,
                ph_nop1     = 4'd2,
                ph_nop2     = 4'd3,
                ph_get_ins  = 4'd4,
                ph_decode   = 4'd5,
                ph_perform  = 4'd6,
                ph_wait     = 4'd7,
                ph_get_ins1 = 4'd8
        } phase_e;

        // Condition that turns the next fetch into a skip
        typedef enum logic [1:0] {
                skip_none    = 2'd0,
                skip_on_zero = 2'd1,
                skip_on_test = 2'd2
        } skip_kind_e;

endpackage

// ==== src/pic_isa_pkg.sv ====
package pic_isa_pkg;

        // Instruction word geometry
        localparam int unsigned insn_w = 12;

        // Major opcode nibble
        localparam int unsigned opc_hi = 11;
        localparam int unsigned opc_lo = 8;

        // Function pair inside a byte-oriented group
        localparam int unsigned fn_hi = 7;
        localparam int unsigned fn_lo = 6;

        // d bit of byte-oriented formats, top of the file address below it
        localparam int unsigned dest_bit = 5;

        typedef enum logic [4:0] {
                op_nop,
                addwf,
                andwf,
                clrf,
                clrw,
                comf,
                decf,
                decfsz,
                incf,
                incfsz,
                iorwf,
                movf,
                movwf,
                rlf,
                rrf,
                subwf,
                swapf,
                xorwf,
                bcf,
                bsf,
                btfsc,
                btfss,
                andlw,
                iorlw,
                movlw,
                xorlw,
                call,
                goto_op,
                retlw
        } opcode_e;

endpackage
